// ==== verilog/axi_pkg.sv ====
package axi_pkg;

  // bus widths of the single-beat AXI subset
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;

  // only okay and decode error are ever returned
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
  } resp_e;

  // write address channel
  typedef struct packed {
    addr_t awaddr;
  } axi_aw_t;

  // write data channel, one beat per transfer
  typedef struct packed {
    data_t wdata;
    strb_t wstrb;
  } axi_w_t;

  // write response channel
  typedef struct packed {
    resp_e bresp;
  } axi_b_t;

  // read address channel
  typedef struct packed {
    addr_t araddr;
  } axi_ar_t;

  // read data channel
  typedef struct packed {
    data_t rdata;
    resp_e rresp;
  } axi_r_t;

endpackage

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

  import axi_pkg::*;

  // address map, two 64 KB regions
  localparam addr_t dram_base   = 32'h0000_0000;
  localparam addr_t cgra_base   = 32'h0001_0000;
  localparam addr_t region_mask = 32'hFFFF_0000;

  // on-chip RAMs, word index from address bits 9:2
  localparam int ram_words = 256;
  localparam int ram_idx_w = $clog2(ram_words);

  // instruction ROM, word index from pc bits 5:2
  localparam int    rom_words = 16;
  localparam int    rom_idx_w = $clog2(rom_words);
  localparam string rom_file  = "rom_init.hex";

  // crossbar target, sel_none goes to the error responder
  typedef enum logic [1:0] {
    sel_dram,
    sel_cgra,
    sel_none
  } slave_sel_e;

endpackage

// ==== verilog/inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom import axi_pkg::*, soc_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  addr_t pc,
  input  logic  fetch_stall,
  output data_t instr
);

  data_t rom [rom_words];

  // program image loaded at elaboration
  initial begin
    $readmemh(rom_file, rom);
  end

  // one word per cycle, held while the core stalls
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr <= '0;
    end else if (!fetch_stall) begin
      // byte address to word index
      instr <= rom[pc[rom_idx_w+1:2]];
    end
  end

endmodule

// ==== verilog/axi_ram_slave.sv ====
`timescale 1ns/1ps

module axi_ram_slave import axi_pkg::*, soc_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_aw_t aw,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_w_t  w,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_b_t  b,
  input  logic    ar_valid,
  output logic    ar_ready,
  input  axi_ar_t ar,
  output logic    r_valid,
  input  logic    r_ready,
  output axi_r_t  r
);

  typedef enum logic {
    st_idle,
    st_resp
  } state_e;

  typedef logic [ram_idx_w-1:0] idx_t;

  state_e wr_state;
  state_e rd_state;
  data_t  mem [ram_words];

  // request held from acceptance until the access cycle
  idx_t   wr_idx;
  data_t  wr_data;
  strb_t  wr_strb;
  idx_t   rd_idx;
  data_t  rd_data;

  logic   wr_acc;
  logic   rd_acc;
  logic   wr_do;
  logic   rd_do;

  // both write readies only while idle, so aw and w pair up
  assign aw_ready = (wr_state == st_idle);
  assign w_ready  = aw_ready;
  assign ar_ready = (rd_state == st_idle);

  assign wr_acc = aw_ready && aw_valid && w_valid;
  assign rd_acc = ar_ready && ar_valid;
  // memory is touched on the first cycle in st_resp
  assign wr_do  = (wr_state == st_resp) && !b_valid;
  assign rd_do  = (rd_state == st_resp) && !r_valid;

  assign b = '{bresp: resp_okay};
  assign r = '{rdata: rd_data, rresp: resp_okay};

  // write fsm
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= st_idle;
      b_valid  <= 1'b0;
    end else begin
      case (wr_state)
        st_idle: begin
          if (wr_acc) begin
            wr_state <= st_resp;
          end
        end
        default: begin
          if (wr_do) begin
            b_valid <= 1'b1;
          end else if (b_ready) begin
            // response taken, back to accepting
            b_valid  <= 1'b0;
            wr_state <= st_idle;
          end
        end
      endcase
    end
  end

  // read fsm
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= st_idle;
      r_valid  <= 1'b0;
    end else begin
      case (rd_state)
        st_idle: begin
          if (rd_acc) begin
            rd_state <= st_resp;
          end
        end
        default: begin
          if (rd_do) begin
            r_valid <= 1'b1;
          end else if (r_ready) begin
            r_valid  <= 1'b0;
            rd_state <= st_idle;
          end
        end
      endcase
    end
  end

  // request capture, upper address bits of the region alias
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      wr_idx  <= aw.awaddr[ram_idx_w+1:2];
      wr_data <= w.wdata;
      wr_strb <= w.wstrb;
    end
    if (rd_acc) begin
      rd_idx <= ar.araddr[ram_idx_w+1:2];
    end
    // read data stays put until the next read
    if (rd_do) begin
      rd_data <= mem[rd_idx];
    end
  end

  // array, cleared on reset, byte lanes written per strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ram_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_do) begin
      for (int i = 0; i < strb_w; i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== verilog/axi_xbar_1to2.sv ====
`timescale 1ns/1ps

module axi_xbar_1to2 import axi_pkg::*, soc_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  // master side
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_aw_t aw,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_w_t  w,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_b_t  b,
  input  logic    ar_valid,
  output logic    ar_ready,
  input  axi_ar_t ar,
  output logic    r_valid,
  input  logic    r_ready,
  output axi_r_t  r,
  // slave 0, data RAM
  output logic    s0_aw_valid,
  input  logic    s0_aw_ready,
  output axi_aw_t s0_aw,
  output logic    s0_w_valid,
  input  logic    s0_w_ready,
  output axi_w_t  s0_w,
  input  logic    s0_b_valid,
  output logic    s0_b_ready,
  input  axi_b_t  s0_b,
  output logic    s0_ar_valid,
  input  logic    s0_ar_ready,
  output axi_ar_t s0_ar,
  input  logic    s0_r_valid,
  output logic    s0_r_ready,
  input  axi_r_t  s0_r,
  // slave 1, CGRA buffer
  output logic    s1_aw_valid,
  input  logic    s1_aw_ready,
  output axi_aw_t s1_aw,
  output logic    s1_w_valid,
  input  logic    s1_w_ready,
  output axi_w_t  s1_w,
  input  logic    s1_b_valid,
  output logic    s1_b_ready,
  input  axi_b_t  s1_b,
  output logic    s1_ar_valid,
  input  logic    s1_ar_ready,
  output axi_ar_t s1_ar,
  input  logic    s1_r_valid,
  output logic    s1_r_ready,
  input  axi_r_t  s1_r
);

  slave_sel_e aw_sel;
  slave_sel_e ar_sel;
  // target of the outstanding transfer, one per direction
  slave_sel_e wr_sel;
  slave_sel_e rd_sel;
  logic       wr_busy;
  logic       rd_busy;
  logic       wr_ready;
  logic       rd_ready;
  logic       wr_acc;
  logic       rd_acc;
  // error responder outputs
  logic       err_b_valid;
  logic       err_r_valid;

  function automatic slave_sel_e decode(addr_t addr);
    slave_sel_e sel;
    case (addr & region_mask)
      dram_base: sel = sel_dram;
      cgra_base: sel = sel_cgra;
      default:   sel = sel_none;
    endcase
    return sel;
  endfunction

  assign aw_sel = decode(aw.awaddr);
  assign ar_sel = decode(ar.araddr);

  // payloads fan out to both slaves, only the valids are steered
  assign s0_aw = aw;
  assign s1_aw = aw;
  assign s0_w  = w;
  assign s1_w  = w;
  assign s0_ar = ar;
  assign s1_ar = ar;

  // no new request reaches a slave while its direction is busy
  assign s0_aw_valid = aw_valid && !wr_busy && (aw_sel == sel_dram);
  assign s0_w_valid  = w_valid && !wr_busy && (aw_sel == sel_dram);
  assign s1_aw_valid = aw_valid && !wr_busy && (aw_sel == sel_cgra);
  assign s1_w_valid  = w_valid && !wr_busy && (aw_sel == sel_cgra);
  assign s0_ar_valid = ar_valid && !rd_busy && (ar_sel == sel_dram);
  assign s1_ar_valid = ar_valid && !rd_busy && (ar_sel == sel_cgra);

  // ready follows the decoded slave, unmapped addresses always accept
  always_comb begin
    case (aw_sel)
      sel_dram: wr_ready = s0_aw_ready && s0_w_ready;
      sel_cgra: wr_ready = s1_aw_ready && s1_w_ready;
      default:  wr_ready = 1'b1;
    endcase
    case (ar_sel)
      sel_dram: rd_ready = s0_ar_ready;
      sel_cgra: rd_ready = s1_ar_ready;
      default:  rd_ready = 1'b1;
    endcase
  end

  assign aw_ready = wr_ready && !wr_busy;
  assign w_ready  = aw_ready;
  assign ar_ready = rd_ready && !rd_busy;

  // aw and w are taken on the same edge
  assign wr_acc = aw_ready && aw_valid && w_valid;
  assign rd_acc = ar_ready && ar_valid;

  // responses come back from the stored target
  always_comb begin
    case (wr_sel)
      sel_dram: begin
        b_valid = s0_b_valid;
        b       = s0_b;
      end
      sel_cgra: begin
        b_valid = s1_b_valid;
        b       = s1_b;
      end
      default: begin
        b_valid = err_b_valid;
        b       = '{bresp: resp_decerr};
      end
    endcase
    case (rd_sel)
      sel_dram: begin
        r_valid = s0_r_valid;
        r       = s0_r;
      end
      sel_cgra: begin
        r_valid = s1_r_valid;
        r       = s1_r;
      end
      default: begin
        r_valid = err_r_valid;
        r       = '{rdata: '0, rresp: resp_decerr};
      end
    endcase
  end

  assign s0_b_ready = b_ready && wr_busy && (wr_sel == sel_dram);
  assign s1_b_ready = b_ready && wr_busy && (wr_sel == sel_cgra);
  assign s0_r_ready = r_ready && rd_busy && (rd_sel == sel_dram);
  assign s1_r_ready = r_ready && rd_busy && (rd_sel == sel_cgra);

  // write direction tracking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_busy     <= 1'b0;
      wr_sel      <= sel_none;
      err_b_valid <= 1'b0;
    end else begin
      if (wr_acc) begin
        wr_busy <= 1'b1;
        wr_sel  <= aw_sel;
      end else if (b_valid && b_ready) begin
        wr_busy <= 1'b0;
      end
      // decode error answers one cycle after acceptance, like the RAMs
      if (wr_busy && (wr_sel == sel_none) && !err_b_valid) begin
        err_b_valid <= 1'b1;
      end else if (err_b_valid && b_ready) begin
        err_b_valid <= 1'b0;
      end
    end
  end

  // read direction tracking, independent of writes
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_busy     <= 1'b0;
      rd_sel      <= sel_none;
      err_r_valid <= 1'b0;
    end else begin
      if (rd_acc) begin
        rd_busy <= 1'b1;
        rd_sel  <= ar_sel;
      end else if (r_valid && r_ready) begin
        rd_busy <= 1'b0;
      end
      if (rd_busy && (rd_sel == sel_none) && !err_r_valid) begin
        err_r_valid <= 1'b1;
      end else if (err_r_valid && r_ready) begin
        err_r_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== verilog/soc_top.sv ====
`timescale 1ns/1ps

module soc_top import axi_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  // master port from the CPU
  input  logic    aw_valid,
  output logic    aw_ready,
  input  axi_aw_t aw,
  input  logic    w_valid,
  output logic    w_ready,
  input  axi_w_t  w,
  output logic    b_valid,
  input  logic    b_ready,
  output axi_b_t  b,
  input  logic    ar_valid,
  output logic    ar_ready,
  input  axi_ar_t ar,
  output logic    r_valid,
  input  logic    r_ready,
  output axi_r_t  r,
  // instruction fetch
  input  addr_t   pc,
  input  logic    fetch_stall,
  output data_t   instr
);

  // crossbar to data RAM
  logic    s0_aw_valid, s0_aw_ready, s0_w_valid, s0_w_ready, s0_b_valid;
  logic    s0_b_ready, s0_ar_valid, s0_ar_ready, s0_r_valid, s0_r_ready;
  axi_aw_t s0_aw;
  axi_w_t  s0_w;
  axi_b_t  s0_b;
  axi_ar_t s0_ar;
  axi_r_t  s0_r;

  // crossbar to CGRA buffer
  logic    s1_aw_valid, s1_aw_ready, s1_w_valid, s1_w_ready, s1_b_valid;
  logic    s1_b_ready, s1_ar_valid, s1_ar_ready, s1_r_valid, s1_r_ready;
  axi_aw_t s1_aw;
  axi_w_t  s1_w;
  axi_b_t  s1_b;
  axi_ar_t s1_ar;
  axi_r_t  s1_r;

  inst_rom u_inst_rom (.clk, .arst_n, .pc, .fetch_stall, .instr);

  // names line up with the crossbar ports
  axi_xbar_1to2 u_xbar (.*);

  // 0x0000_0000 region
  axi_ram_slave u_dram (
    .clk      (clk),
    .arst_n   (arst_n),
    .aw_valid (s0_aw_valid), .aw_ready (s0_aw_ready), .aw (s0_aw),
    .w_valid  (s0_w_valid),  .w_ready  (s0_w_ready),  .w  (s0_w),
    .b_valid  (s0_b_valid),  .b_ready  (s0_b_ready),  .b  (s0_b),
    .ar_valid (s0_ar_valid), .ar_ready (s0_ar_ready), .ar (s0_ar),
    .r_valid  (s0_r_valid),  .r_ready  (s0_r_ready),  .r  (s0_r)
  );

  // 0x0001_0000 region, accelerator array buffer
  axi_ram_slave u_cgra_buf (
    .clk      (clk),
    .arst_n   (arst_n),
    .aw_valid (s1_aw_valid), .aw_ready (s1_aw_ready), .aw (s1_aw),
    .w_valid  (s1_w_valid),  .w_ready  (s1_w_ready),  .w  (s1_w),
    .b_valid  (s1_b_valid),  .b_ready  (s1_b_ready),  .b  (s1_b),
    .ar_valid (s1_ar_valid), .ar_ready (s1_ar_ready), .ar (s1_ar),
    .r_valid  (s1_r_valid),  .r_ready  (s1_r_ready),  .r  (s1_r)
  );

endmodule

// ==== verif/clk_rst_gen.sv ====
`timescale 1ns/1ps

module clk_rst_gen (
  output logic clk,
  output logic arst_n
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 5;

  // free running 20 ns clock
  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset held over the first rising edges, released mid-cycle
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== verif/soc_asserts.sv ====
`timescale 1ns/1ps

module soc_asserts import axi_pkg::*; (
  input logic   clk,
  input logic   arst_n,
  input logic   aw_valid,
  input logic   aw_ready,
  input logic   w_valid,
  input logic   b_valid,
  input logic   b_ready,
  input axi_b_t b,
  input logic   r_valid,
  input logic   r_ready,
  input axi_r_t r
);

  // write accepted on the master side and not yet answered
  logic wr_pending;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_pending <= 1'b0;
    end else if (aw_valid && aw_ready && w_valid) begin
      wr_pending <= 1'b1;
    end else if (b_valid && b_ready) begin
      wr_pending <= 1'b0;
    end
  end

  // write response held until taken
  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b_valid or b changed before b_ready");

  // read data and valid frozen under back-pressure
  r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r_valid or r changed before r_ready");

  // one write in flight at a time
  aw_block: assert property (@(posedge clk) disable iff (!arst_n)
    wr_pending |-> !aw_ready)
    else $error("aw_ready high while a write is outstanding");

endmodule

// ==== verif/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb import axi_pkg::*, soc_pkg::*; ();

  localparam int cycle_ns = 20;

  typedef enum logic [1:0] {
    op_write,
    op_read,
    op_fetch
  } op_e;

  // one row of the stimulus table
  typedef struct packed {
    op_e   op;
    addr_t addr;
    data_t data;
    strb_t strb;
    logic  stall;
    resp_e exp_resp;
    int    delay;
  } entry_t;

  logic    clk, arst_n;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic    ar_valid, ar_ready, r_valid, r_ready, fetch_stall;
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  axi_ar_t ar;
  axi_r_t  r;
  addr_t   pc;
  data_t   instr;

  entry_t  tests [$];
  int      n_tests;
  int      n_checks;
  int      n_errors;
  // reference model of both RAMs and the ROM image
  data_t   model_dram [ram_words];
  data_t   model_cgra [ram_words];
  data_t   rom_model  [rom_words];
  data_t   last_instr;

  clk_rst_gen u_clk_rst (.clk, .arst_n);

  soc_top uut (.*);

  bind axi_xbar_1to2 soc_asserts u_asserts (
    .clk      (clk),
    .arst_n   (arst_n),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    n_errors++;
  endtask

  task automatic add_entry(input op_e op, input addr_t addr, input data_t data,
                           input strb_t strb, input logic stall, input resp_e exp_resp,
                           input int delay);
    tests.push_back('{op: op, addr: addr, data: data, strb: strb, stall: stall,
                      exp_resp: exp_resp, delay: delay});
  endtask

  // word index from bits 9:2, upper bits inside a region alias
  function automatic data_t model_read(input addr_t addr);
    data_t val;
    val = '0;
    if ((addr & region_mask) == dram_base) begin
      val = model_dram[addr[9:2]];
    end else if ((addr & region_mask) == cgra_base) begin
      val = model_cgra[addr[9:2]];
    end
    return val;
  endfunction

  task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
    data_t val;
    val = model_read(addr);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        val[8*i +: 8] = data[8*i +: 8];
      end
    end
    // unmapped addresses touch neither array
    if ((addr & region_mask) == dram_base) begin
      model_dram[addr[9:2]] = val;
    end else if ((addr & region_mask) == cgra_base) begin
      model_cgra[addr[9:2]] = val;
    end
  endtask

  task automatic set_ready(input logic is_read, input logic val);
    if (is_read) begin
      r_ready <= val;
    end else begin
      b_ready <= val;
    end
  endtask

  // aw and w raised together, dropped on the handshake edge
  task automatic send_write(input addr_t addr, input data_t data, input strb_t strb);
    @(posedge clk);
    aw_valid <= 1'b1;
    w_valid  <= 1'b1;
    aw       <= '{awaddr: addr};
    w        <= '{wdata: data, wstrb: strb};
    @(negedge clk);
    while (!(aw_ready && w_ready)) @(negedge clk);
    @(posedge clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
  endtask

  task automatic send_read(input addr_t addr);
    @(posedge clk);
    ar_valid <= 1'b1;
    ar       <= '{araddr: addr};
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    @(posedge clk);
    ar_valid <= 1'b0;
  endtask

  // called on the acceptance edge, ready held low for delay cycles
  task automatic wait_response(input logic is_read, input int delay,
                               output axi_r_t resp, output int lat);
    axi_r_t first;
    axi_r_t now;
    logic   valid;
    logic   ready;
    logic   addr_ready;
    logic   seen;
    logic   done;
    int     cycles;
    seen   = 1'b0;
    done   = 1'b0;
    cycles = 0;
    lat    = -1;
    first  = '0;
    set_ready(is_read, delay == 0);
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (is_read) begin
        valid      = r_valid;
        ready      = r_ready;
        now        = r;
        addr_ready = ar_ready;
      end else begin
        valid      = b_valid;
        ready      = b_ready;
        now        = '{rdata: '0, rresp: b.bresp};
        addr_ready = aw_ready;
      end
      if (addr_ready) begin
        report_problem("address ready high while a transfer is outstanding");
      end
      if (valid && !seen) begin
        seen  = 1'b1;
        first = now;
        lat   = cycles - 1;
      end else if (valid && now !== first) begin
        report_problem("response changed while waiting for ready");
      end else if (!valid && seen) begin
        report_problem("response valid dropped before ready");
      end
      done = (valid && ready) || (seen && !valid);
      @(posedge clk);
      if (done) begin
        set_ready(is_read, 1'b0);
      end else if (cycles >= delay) begin
        set_ready(is_read, 1'b1);
      end
    end
    resp = first;
  endtask

  task automatic build_table();
    addr_t a;
    // fetch stalled since reset keeps instr at zero
    add_entry(op_fetch, 32'h0000_0008, '0, 4'h0, 1'b1, resp_okay, 0);
    // full words in both regions
    add_entry(op_write, 32'h0000_0000, 32'h1122_3344, 4'hf, 1'b0, resp_okay, 0);
    add_entry(op_write, 32'h0001_0000, 32'ha5a5_0001, 4'hf, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0000_0000, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0001_0000, '0, 4'h0, 1'b0, resp_okay, 2);
    add_entry(op_write, 32'h0000_0004, 32'hdead_beef, 4'hf, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0001_0004, '0, 4'h0, 1'b0, resp_okay, 0);
    // byte strobes
    add_entry(op_write, 32'h0000_0008, 32'hcafe_f00d, 4'hf, 1'b0, resp_okay, 0);
    add_entry(op_write, 32'h0000_0008, 32'h0000_00aa, 4'h1, 1'b0, resp_okay, 1);
    add_entry(op_write, 32'h0000_0008, 32'h5500_0000, 4'h8, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0000_0008, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_write, 32'h0001_00fc, 32'h1234_5678, 4'h6, 1'b0, resp_okay, 3);
    add_entry(op_read,  32'h0001_00fc, '0, 4'h0, 1'b0, resp_okay, 0);
    // index 1 reached through an aliased address
    add_entry(op_write, 32'h0001_0404, 32'h0bad_cafe, 4'hf, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0001_0004, '0, 4'h0, 1'b0, resp_okay, 0);
    // unmapped addresses
    add_entry(op_write, 32'h0002_0000, 32'hffff_ffff, 4'hf, 1'b0, resp_decerr, 0);
    add_entry(op_read,  32'h0002_0000, '0, 4'h0, 1'b0, resp_decerr, 0);
    add_entry(op_write, 32'h8000_0008, 32'h0000_0000, 4'hf, 1'b0, resp_decerr, 2);
    add_entry(op_read,  32'h0000_0000, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'h0000_0008, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_read,  32'hffff_fffc, '0, 4'h0, 1'b0, resp_decerr, 1);
    // random data, strobes and back-pressure
    for (int k = 0; k < 6; k++) begin
      a = ((k % 2) ? cgra_base : dram_base) | (addr_t'($urandom_range(0, 255)) << 2);
      add_entry(op_write, a, $urandom(), strb_t'($urandom_range(1, 15)), 1'b0, resp_okay,
                $urandom_range(0, 8));
      add_entry(op_read, a, '0, 4'h0, 1'b0, resp_okay, $urandom_range(0, 8));
    end
    add_entry(op_write, 32'h0003_0040, $urandom(), 4'hf, 1'b0, resp_decerr,
              $urandom_range(1, 8));
    add_entry(op_read, 32'h0003_0040, '0, 4'h0, 1'b0, resp_decerr, $urandom_range(1, 8));
    // instruction fetch, stall holds the last word
    add_entry(op_fetch, 32'h0000_0000, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_fetch, 32'h0000_0014, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_fetch, 32'h0000_003c, '0, 4'h0, 1'b1, resp_okay, 0);
    add_entry(op_fetch, 32'h0000_003c, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_fetch, 32'h0000_0040, '0, 4'h0, 1'b0, resp_okay, 0);
    add_entry(op_fetch, 32'h0000_0024, '0, 4'h0, 1'b0, resp_okay, 0);
  endtask

  initial begin : main
    entry_t t;
    op_e    op;
    axi_r_t resp;
    int     lat;
    int     errs_before;
    void'($urandom(73029));
    $readmemh(rom_file, rom_model);
    for (int i = 0; i < ram_words; i++) begin
      model_dram[i] = '0;
      model_cgra[i] = '0;
    end
    last_instr  = '0;
    aw_valid    <= 1'b0;
    w_valid     <= 1'b0;
    b_ready     <= 1'b0;
    ar_valid    <= 1'b0;
    r_ready     <= 1'b0;
    aw          <= '0;
    w           <= '0;
    ar          <= '0;
    pc          <= '0;
    fetch_stall <= 1'b1;
    build_table();
    n_tests = tests.size();
    wait (arst_n === 1'b1);
    @(negedge clk);
    // idle state straight out of reset
    errs_before = n_errors;
    check("aw_ready", 32'(aw_ready), 1);
    check("w_ready", 32'(w_ready), 1);
    check("ar_ready", 32'(ar_ready), 1);
    check("b_valid", 32'(b_valid), 0);
    check("r_valid", 32'(r_valid), 0);
    check("instr", instr, 0);
    $display("reset state: %s", (n_errors == errs_before) ? "pass" : "fail");
    foreach (tests[i]) begin
      t           = tests[i];
      op          = t.op;
      errs_before = n_errors;
      case (t.op)
        op_write: begin
          send_write(t.addr, t.data, t.strb);
          wait_response(1'b0, t.delay, resp, lat);
          check("bresp", 32'(resp.rresp), 32'(t.exp_resp));
          check("b latency", lat, 1);
          model_write(t.addr, t.data, t.strb);
        end
        op_read: begin
          send_read(t.addr);
          wait_response(1'b1, t.delay, resp, lat);
          check("rresp", 32'(resp.rresp), 32'(t.exp_resp));
          check("rdata", resp.rdata, model_read(t.addr));
          check("r latency", lat, 1);
        end
        default: begin
          @(posedge clk);
          pc          <= t.addr;
          fetch_stall <= t.stall;
          // ROM registers the word on this edge
          @(posedge clk);
          @(negedge clk);
          if (!t.stall) begin
            last_instr = rom_model[t.addr[5:2]];
          end
          check("instr", instr, last_instr);
        end
      endcase
      $display("test %0d %s addr 0x%08h: %s", i, op.name(), t.addr,
               (n_errors == errs_before) ? "pass" : "fail");
    end
    $display("%0d tests run, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // generous bound of 40 cycles per table row
  initial begin : watchdog
    wait (n_tests > 0);
    #(n_tests * 40 * cycle_ns);
    $display("timeout: the tests did not finish within %0d cycles", n_tests * 40);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/axi_pkg.sv
verilog/soc_pkg.sv
verilog/inst_rom.sv
verilog/axi_ram_slave.sv
verilog/axi_xbar_1to2.sv
verilog/soc_top.sv
verif/clk_rst_gen.sv
verif/soc_asserts.sv
verif/soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module soc_tb -f sim.f \
  && ./obj_dir/Vsoc_tb 2>&1 | tee sim.log \
  && ! grep -q -e "Finished with errors" -e "%Error" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== rom_init.hex ====
// rom words 0 to 15, one 32-bit instruction per line in hex
00000093
00100113
00208193
10000237
00322023
00022283
00128293
00522023
fe5ff06f
00010337
00632023
00032383
00138393
00732023
0000006f
00000013
